//--- logic/busPkg.sv
package busPkg;

    //////////////////////////////
    // widths and depths
    //////////////////////////////
    localparam int dataWidth      = 8;
    localparam int memDepth       = 256;
    localparam int addrWidth      = $clog2(memDepth);
    localparam int slaveCount     = 4;
    localparam int slaveIdWidth   = 2;
    localparam int burstLen       = 4;
    localparam int frameWidth     = 15;
    localparam int burstDataWidth = dataWidth * burstLen;
    localparam int wordCountWidth = 3;
    localparam int bitIdxWidth    = $clog2(dataWidth);
    localparam int wordIdxWidth   = $clog2(burstLen);
    // covers the 15 frame bits and up to 32 data bits
    localparam int linkCntWidth   = $clog2(burstDataWidth + 1);

    localparam logic [2:0] startPattern = 3'b111;

    //////////////////////////////
    // queues and credits
    //////////////////////////////
    localparam int cmdDepth         = 4;
    localparam int resultDepth      = 4;
    localparam int resultCredits    = 2;
    localparam int resultCountWidth = $clog2(resultDepth + 1);
    localparam int creditWidth      = $clog2(resultCredits + 1);

    //////////////////////////////
    // packed structs
    //////////////////////////////
    typedef struct packed {
        logic                    write;
        logic                    burst;
        logic [slaveIdWidth-1:0] slaveId;
        logic [addrWidth-1:0]    addr;
    } cmdInfoT;

    // word i sits in data[i*dataWidth +: dataWidth]
    typedef struct packed {
        cmdInfoT                   info;
        logic [burstDataWidth-1:0] data;
    } hostCmdT;

    // sent msb first: start, id, r/w, burst, address
    typedef struct packed {
        logic [2:0]              start;
        logic [slaveIdWidth-1:0] slaveId;
        logic                    write;
        logic                    burst;
        logic [addrWidth-1:0]    addr;
    } frameT;

    typedef struct packed {
        frameT                     frame;
        logic [wordCountWidth-1:0] wordCount;
        logic [burstDataWidth-1:0] wrData;
        cmdInfoT                   info;
    } linkReqT;

    typedef struct packed {
        cmdInfoT                   info;
        logic [burstDataWidth-1:0] data;
    } resultT;

endpackage

//--- logic/creditFifo.sv
`timescale 1ns/1ps

module creditFifo #(
    parameter type payloadT = logic [7:0],
    parameter int  depth    = 4
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       push,
    input  payloadT                    pushData,
    input  logic                       pop,
    output payloadT                    popData,
    output logic                       empty,
    output logic [$clog2(depth+1)-1:0] count
);

    payloadT                   mem [depth];
    logic [$clog2(depth)-1:0]  wrPtr;
    logic [$clog2(depth)-1:0]  rdPtr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == depth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == depth - 1) ? '0 : rdPtr + 1'b1;
            end
            // simultaneous push and pop leaves occupancy unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    // oldest entry always visible at the head
    assign popData = mem[rdPtr];
    assign empty   = (count == '0);

endmodule

//--- logic/hostCmdDecoder.sv
`timescale 1ns/1ps

module hostCmdDecoder import busPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    cmdValid,
    input  hostCmdT cmd,
    output logic    cmdCredit,
    output logic    reqValid,
    output linkReqT req,
    input  logic    reqReady
);

    hostCmdT head;
    logic    empty;
    logic    pop;

    // host only sends with a credit in hand, so the queue never overflows
    creditFifo #(
        .payloadT (hostCmdT),
        .depth    (cmdDepth)
    ) cmdFifo (
        .clk      (clk),
        .rstN     (rstN),
        .push     (cmdValid),
        .pushData (cmd),
        .pop      (pop),
        .popData  (head),
        .empty    (empty),
        .count    ()
    );

    assign reqValid = !empty;
    assign pop      = reqValid && reqReady;

    // link request built straight from the queue head
    always_comb begin
        req.frame.start   = startPattern;
        req.frame.slaveId = head.info.slaveId;
        req.frame.write   = head.info.write;
        req.frame.burst   = head.info.burst;
        req.frame.addr    = head.info.addr;
        req.wordCount     = head.info.burst ? wordCountWidth'(burstLen) : wordCountWidth'(1);
        req.wrData        = head.data;
        req.info          = head.info;
    end

    // one credit back per command leaving the queue
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cmdCredit <= 1'b0;
        end else begin
            cmdCredit <= pop;
        end
    end

endmodule

//--- logic/serialMaster.sv
`timescale 1ns/1ps

module serialMaster import busPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  reqValid,
    input  linkReqT               req,
    output logic                  reqReady,
    input  logic                  space,
    output logic                  control,
    output logic                  wrD,
    output logic                  valid,
    output logic                  last,
    input  logic [slaveCount-1:0] rD,
    input  logic [slaveCount-1:0] ready,
    output logic                  respValid,
    output resultT                resp
);

    typedef enum logic [2:0] {
        mIdle,
        mFrame,
        mWrite,
        mRead,
        mDone
    } stateT;

    stateT                     state;
    logic [frameWidth-1:0]     reqFrame;
    logic [frameWidth-1:0]     frameSh;
    logic [burstDataWidth-1:0] dataReg;
    cmdInfoT                   info;
    logic [wordCountWidth-1:0] wordCnt;
    logic [linkCntWidth-1:0]   bitCnt;
    logic [linkCntWidth-1:0]   totalBits;
    logic                      accept;
    logic                      selRd;
    logic                      selReady;

    // data bit n maps to word n/8, msb of each word first
    function automatic logic [wordIdxWidth+bitIdxWidth-1:0] bitPos(
        input logic [linkCntWidth-1:0] cnt
    );
        return {cnt[bitIdxWidth +: wordIdxWidth], ~cnt[bitIdxWidth-1:0]};
    endfunction

    assign reqFrame  = req.frame;
    assign accept    = reqValid && reqReady;
    assign totalBits = linkCntWidth'(wordCnt * dataWidth);
    assign selRd     = rD[info.slaveId];
    assign selReady  = ready[info.slaveId];

    assign resp.info = info;
    assign resp.data = info.write ? '0 : dataReg;

    //////////////////////////////
    // link FSM
    //////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= mIdle;
            reqReady  <= 1'b0;
            control   <= 1'b0;
            wrD       <= 1'b0;
            valid     <= 1'b0;
            last      <= 1'b0;
            respValid <= 1'b0;
            bitCnt    <= '0;
        end else begin
            case (state)
                mIdle: begin
                    reqReady <= space && !accept;
                    if (accept) begin
                        // first frame bit goes out right away
                        control <= reqFrame[frameWidth-1];
                        bitCnt  <= linkCntWidth'(1);
                        state   <= mFrame;
                    end
                end
                mFrame: begin
                    if (bitCnt == linkCntWidth'(frameWidth)) begin
                        control <= 1'b0;
                        if (info.write) begin
                            valid  <= 1'b1;
                            wrD    <= dataReg[bitPos('0)];
                            last   <= (totalBits == linkCntWidth'(1));
                            bitCnt <= linkCntWidth'(1);
                            state  <= mWrite;
                        end else begin
                            bitCnt <= '0;
                            state  <= mRead;
                        end
                    end else begin
                        control <= frameSh[frameWidth-1];
                        bitCnt  <= bitCnt + 1'b1;
                    end
                end
                mWrite: begin
                    if (bitCnt == totalBits) begin
                        valid     <= 1'b0;
                        last      <= 1'b0;
                        wrD       <= 1'b0;
                        respValid <= 1'b1;
                        state     <= mDone;
                    end else begin
                        wrD    <= dataReg[bitPos(bitCnt)];
                        last   <= (bitCnt == totalBits - 1'b1);
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                mRead: begin
                    // a gap in ready just holds the count
                    if (selReady) begin
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == totalBits - 1'b1) begin
                            respValid <= 1'b1;
                            state     <= mDone;
                        end
                    end
                end
                mDone: begin
                    respValid <= 1'b0;
                    state     <= mIdle;
                end
                default: state <= mIdle;
            endcase
        end
    end

    //////////////////////////////
    // frame and data registers
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            frameSh <= {reqFrame[frameWidth-2:0], 1'b0};
            dataReg <= req.info.write ? req.wrData : '0;
            info    <= req.info;
            wordCnt <= req.wordCount;
        end else begin
            if (state == mFrame) begin
                frameSh <= {frameSh[frameWidth-2:0], 1'b0};
            end
            if (state == mRead && selReady) begin
                dataReg[bitPos(bitCnt)] <= selRd;
            end
        end
    end

endmodule

//--- logic/serialSlave.sv
`timescale 1ns/1ps

module serialSlave import busPkg::*; #(
    parameter int slaveIndex = 0
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wrD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);

    typedef enum logic [1:0] {
        sIdle,
        sCapture,
        sWrite,
        sRead
    } stateT;

    stateT                   state;
    logic [dataWidth-1:0]    mem [memDepth];
    logic [1:0]              hist;
    logic [3:0]              capCnt;
    logic [frameWidth-5:0]   body;
    logic [addrWidth-1:0]    addr;
    logic [dataWidth-1:0]    rdSh;
    logic [dataWidth-1:0]    rdWord;
    logic [dataWidth-2:0]    wrSh;
    logic [bitIdxWidth-1:0]  bitIdx;
    logic [wordIdxWidth-1:0] wordIdx;
    logic                    isBurst;
    frameT                   frame;
    logic                    frameDone;
    logic                    hit;
    logic                    startRead;
    logic                    wordDone;
    logic                    moreWords;
    logic                    nextWord;
    logic                    memWe;

    // full frame on the cycle its last bit is on the line
    assign frame     = {startPattern, body, control};
    assign frameDone = (state == sCapture) && (capCnt == 4'(frameWidth - 4));
    assign hit       = frameDone && (frame.slaveId == slaveIdWidth'(slaveIndex));
    assign startRead = hit && !frame.write;
    assign rdWord    = mem[startRead ? frame.addr : addr];
    assign wordDone  = (state == sRead) && (&bitIdx);
    assign moreWords = isBurst && (wordIdx != wordIdxWidth'(burstLen - 1));
    assign nextWord  = wordDone && moreWords;
    assign memWe     = (state == sWrite) && valid && (&bitIdx);

    //////////////////////////////
    // frame detect and data phase
    //////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= sIdle;
            hist    <= '0;
            capCnt  <= '0;
            bitIdx  <= '0;
            wordIdx <= '0;
            ready   <= 1'b0;
            rD      <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if ({hist, control} == startPattern) begin
                        hist   <= '0;
                        capCnt <= '0;
                        state  <= sCapture;
                    end else begin
                        hist <= {hist[0], control};
                    end
                end
                sCapture: begin
                    capCnt  <= capCnt + 1'b1;
                    bitIdx  <= '0;
                    wordIdx <= '0;
                    // other slaves drop out and ignore the data phase
                    if (frameDone) begin
                        if (!hit) begin
                            state <= sIdle;
                        end else if (frame.write) begin
                            state <= sWrite;
                        end else begin
                            ready <= 1'b1;
                            rD    <= rdWord[dataWidth-1];
                            state <= sRead;
                        end
                    end
                end
                sWrite: begin
                    if (valid) begin
                        bitIdx <= bitIdx + 1'b1;
                        if (last) begin
                            state <= sIdle;
                        end
                    end
                end
                sRead: begin
                    bitIdx <= bitIdx + 1'b1;
                    if (nextWord) begin
                        rD      <= rdWord[dataWidth-1];
                        wordIdx <= wordIdx + 1'b1;
                    end else if (wordDone) begin
                        ready <= 1'b0;
                        rD    <= 1'b0;
                        state <= sIdle;
                    end else begin
                        rD <= rdSh[dataWidth-1];
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sCapture) begin
            body <= {body[frameWidth-6:0], control};
        end
        // reads prefetch, so the address runs one word ahead
        if (hit) begin
            isBurst <= frame.burst;
            addr    <= frame.write ? frame.addr : frame.addr + 1'b1;
        end else if (nextWord || memWe) begin
            addr <= addr + 1'b1;
        end
        if (startRead || nextWord) begin
            rdSh <= {rdWord[dataWidth-2:0], 1'b0};
        end else if (state == sRead) begin
            rdSh <= {rdSh[dataWidth-2:0], 1'b0};
        end
        if (state == sWrite && valid) begin
            wrSh <= {wrSh[dataWidth-3:0], wrD};
        end
        if (memWe) begin
            mem[addr] <= {wrSh, wrD};
        end
    end

endmodule

//--- logic/resultCollector.sv
`timescale 1ns/1ps

module resultCollector import busPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   respValid,
    input  resultT resp,
    output logic   space,
    output logic   resultValid,
    output resultT result,
    input  logic   resultCredit
);

    resultT                      head;
    logic                        fifoEmpty;
    logic [resultCountWidth-1:0] fifoCount;
    logic [creditWidth-1:0]      credits;
    logic                        pop;

    creditFifo #(
        .payloadT (resultT),
        .depth    (resultDepth)
    ) resultFifo (
        .clk      (clk),
        .rstN     (rstN),
        .push     (respValid),
        .pushData (resp),
        .pop      (pop),
        .popData  (head),
        .empty    (fifoEmpty),
        .count    (fifoCount)
    );

    // master runs one transfer at a time and samples space only while idle,
    // so a free slot here is the slot promised to its next transfer
    assign space = (fifoCount < resultDepth);
    assign pop   = !fifoEmpty && (credits != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            credits     <= creditWidth'(resultCredits);
        end else begin
            resultValid <= pop;
            case ({pop, resultCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result <= head;
        end
    end

endmodule

//--- logic/busTop.sv
`timescale 1ns/1ps

module busTop import busPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    cmdValid,
    input  hostCmdT cmd,
    output logic    cmdCredit,
    output logic    resultValid,
    output resultT  result,
    input  logic    resultCredit
);

    linkReqT               req;
    logic                  reqValid;
    logic                  reqReady;
    logic                  space;
    logic                  control;
    logic                  wrD;
    logic                  valid;
    logic                  last;
    logic [slaveCount-1:0] rD;
    logic [slaveCount-1:0] ready;
    logic                  respValid;
    resultT                resp;

    hostCmdDecoder decoder (
        .clk       (clk),
        .rstN      (rstN),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .cmdCredit (cmdCredit),
        .reqValid  (reqValid),
        .req       (req),
        .reqReady  (reqReady)
    );

    serialMaster master (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .req       (req),
        .reqReady  (reqReady),
        .space     (space),
        .control   (control),
        .wrD       (wrD),
        .valid     (valid),
        .last      (last),
        .rD        (rD),
        .ready     (ready),
        .respValid (respValid),
        .resp      (resp)
    );

    // shared control and write lines, one rD and ready bit per slave
    for (genvar g = 0; g < slaveCount; g++) begin : genSlave
        serialSlave #(
            .slaveIndex (g)
        ) slave (
            .clk     (clk),
            .rstN    (rstN),
            .control (control),
            .wrD     (wrD),
            .valid   (valid),
            .last    (last),
            .rD      (rD[g]),
            .ready   (ready[g])
        );
    end

    resultCollector collector (
        .clk          (clk),
        .rstN         (rstN),
        .respValid    (respValid),
        .resp         (resp),
        .space        (space),
        .resultValid  (resultValid),
        .result       (result),
        .resultCredit (resultCredit)
    );

endmodule

//--- test/busTop_sva.sv
`timescale 1ns/1ps

module busTopSva import busPkg::*; (
    input logic                  clk,
    input logic                  rstN,
    input logic                  control,
    input logic                  valid,
    input logic                  last,
    input logic [slaveCount-1:0] ready
);

    logic [3:0] frameLeft;
    logic       inFrame;

    // start bit seen on the line, then 14 more frame bits follow
    assign inFrame = control || (frameLeft != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            frameLeft <= '0;
        end else if (frameLeft != '0) begin
            frameLeft <= frameLeft - 1'b1;
        end else if (control) begin
            frameLeft <= 4'(frameWidth - 1);
        end
    end

    validQuietInFrame: assert property (@(posedge clk) disable iff (!rstN) inFrame |-> !valid)
        else $error("valid raised during a control frame");

    lastOnlyWithValid: assert property (@(posedge clk) disable iff (!rstN) last |-> valid)
        else $error("last high without valid");

    readyOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(ready))
        else $error("more than one slave drives ready");

endmodule

bind busTop busTopSva busTopSvaInst (
    .clk     (clk),
    .rstN    (rstN),
    .control (control),
    .valid   (valid),
    .last    (last),
    .ready   (ready)
);

//--- test/busChecker.sv
`timescale 1ns/1ps

module busChecker import busPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    cmdValid,
    input  hostCmdT cmd,
    input  logic    cmdCredit,
    input  logic    resultValid,
    input  resultT  result,
    input  logic    resultCredit,
    output int      mismatchCount,
    output int      protocolCount,
    output int      resultCount
);

    hostCmdT              cmdQueue [$];
    logic [dataWidth-1:0] memModel [slaveCount][memDepth];
    bit                   written  [slaveCount][memDepth];
    int                   cmdsSeen;
    int                   creditsSeen;
    int                   hostCredits;

    initial begin
        mismatchCount = 0;
        protocolCount = 0;
        resultCount   = 0;
        cmdsSeen      = 0;
        creditsSeen   = 0;
        hostCredits   = resultCredits;
        foreach (written[s, a]) begin
            written[s][a] = 1'b0;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            mismatchCount++;
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////
    task automatic handleResult();
        hostCmdT              expCmd;
        int                   words;
        logic [addrWidth-1:0] a;
        logic [dataWidth-1:0] word;
        resultCount++;
        if (hostCredits == 0) begin
            $display("result delivered while the host held no result credit");
            protocolCount++;
        end else begin
            hostCredits--;
        end
        if (cmdQueue.size() == 0) begin
            $display("result arrived with no command outstanding");
            protocolCount++;
            return;
        end
        expCmd = cmdQueue.pop_front();
        words  = expCmd.info.burst ? burstLen : 1;
        checkValue("order", expCmd.info, result.info);
        if (expCmd.info.write) begin
            checkValue("write result data", '0, result.data);
            // writes complete in command order, so the model follows results
            for (int i = 0; i < words; i++) begin
                a    = addrWidth'(expCmd.info.addr + i);
                word = expCmd.data[i*dataWidth +: dataWidth];
                memModel[expCmd.info.slaveId][a] = word;
                written[expCmd.info.slaveId][a]  = 1'b1;
            end
        end else begin
            for (int i = 0; i < words; i++) begin
                a = addrWidth'(expCmd.info.addr + i);
                // slaves power up with unknown memory
                if (written[expCmd.info.slaveId][a]) begin
                    checkValue(expCmd.info.burst ? "burst read" : "single read",
                               memModel[expCmd.info.slaveId][a],
                               result.data[i*dataWidth +: dataWidth]);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rstN) begin
            if (cmdValid) begin
                cmdQueue.push_back(cmd);
                cmdsSeen++;
            end
            if (cmdCredit) begin
                creditsSeen++;
                if (creditsSeen > cmdsSeen) begin
                    $display("command credit returned with no command outstanding");
                    protocolCount++;
                end
            end
            if (resultValid) begin
                handleResult();
            end
            if (resultCredit) begin
                hostCredits++;
            end
        end
    end

    task automatic checkEnd();
        if (creditsSeen != cmdsSeen) begin
            $display("command credits returned (%0d) differ from commands accepted (%0d)",
                     creditsSeen, cmdsSeen);
            protocolCount++;
        end
        if (cmdQueue.size() != 0) begin
            $display("%0d commands never produced a result", cmdQueue.size());
            protocolCount++;
        end
    endtask

endmodule

//--- test/busTb.sv
`timescale 1ns/1ps

module busTb import busPkg::*; ();

    localparam int numCmds    = 60;
    localparam int cycleLimit = numCmds * (48 + 10);
    localparam int holdCycles = 150;

    logic    clk;
    logic    rstN;
    logic    cmdValid;
    hostCmdT cmd;
    logic    cmdCredit;
    logic    resultValid;
    resultT  result;
    logic    resultCredit;

    int seed;
    int cmdsSent     = 0;
    int creditsBack  = 0;
    int resultsSeen  = 0;
    int creditsGiven = 0;
    int creditDelay  = 0;
    int holdLeft     = 0;
    int cycles       = 0;
    bit holdDone     = 1'b0;
    int mismatchCount;
    int protocolCount;
    int resultCount;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    busTop busTop_inst (
        .clk          (clk),
        .rstN         (rstN),
        .cmdValid     (cmdValid),
        .cmd          (cmd),
        .cmdCredit    (cmdCredit),
        .resultValid  (resultValid),
        .result       (result),
        .resultCredit (resultCredit)
    );

    busChecker busCheck (
        .clk           (clk),
        .rstN          (rstN),
        .cmdValid      (cmdValid),
        .cmd           (cmd),
        .cmdCredit     (cmdCredit),
        .resultValid   (resultValid),
        .result        (result),
        .resultCredit  (resultCredit),
        .mismatchCount (mismatchCount),
        .protocolCount (protocolCount),
        .resultCount   (resultCount)
    );

    // credits and results tallied on the rising edge
    always @(posedge clk) begin
        if (rstN) begin
            creditsBack <= creditsBack + cmdCredit;
            resultsSeen <= resultsSeen + resultValid;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycleLimit) begin
            $display("timeout: results stopped arriving, %0d of %0d received",
                     resultsSeen, numCmds);
            $display("errors: %0d mismatches, %0d protocol errors", mismatchCount,
                     protocolCount);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic sendCommand();
        logic [31:0] r;
        cmdValid = 1'b0;
        if (cmdsSent < numCmds && cmdsSent - creditsBack < cmdDepth) begin
            r = $random(seed);
            // idle roughly one cycle in four
            if (r[3:2] != 2'b00) begin
                cmd.info.write   = r[0];
                cmd.info.burst   = r[1];
                cmd.info.slaveId = r[5:4];
                // narrow window at the top of memory so reads hit and bursts wrap
                cmd.info.addr    = addrWidth'(8'hfa + r[10:8]);
                cmd.data         = $random(seed);
                cmdValid         = 1'b1;
                cmdsSent++;
            end
        end
    endtask

    task automatic returnCredit();
        resultCredit = 1'b0;
        if (holdLeft > 0) begin
            holdLeft--;
        end else if (creditsGiven < resultsSeen) begin
            if (creditDelay == 0) begin
                resultCredit = 1'b1;
                creditsGiven++;
                creditDelay = {$random(seed)} % 6;
            end else begin
                creditDelay--;
            end
        end
    endtask

    initial begin
        seed         = 32'heb08_1fae;
        rstN         = 1'b0;
        cmdValid     = 1'b0;
        cmd          = '0;
        resultCredit = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        while (resultsSeen < numCmds) begin
            @(negedge clk);
            // withhold result credits once, mid run
            if (cmdsSent == 20 && !holdDone) begin
                holdLeft = holdCycles;
                holdDone = 1'b1;
            end
            sendCommand();
            returnCredit();
        end
        repeat (2) @(negedge clk);
        busCheck.checkEnd();
        $display("errors: %0d mismatches, %0d protocol errors, %0d results checked",
                 mismatchCount, protocolCount, resultCount);
        if (mismatchCount == 0 && protocolCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- build.f
logic/busPkg.sv
logic/creditFifo.sv
logic/hostCmdDecoder.sv
logic/serialMaster.sv
logic/serialSlave.sv
logic/resultCollector.sv
logic/busTop.sv
test/busTop_sva.sv
test/busChecker.sv
test/busTb.sv

//--- Bender.yml
package:
  name: serialBus

sources:
  - logic/busPkg.sv
  - logic/creditFifo.sv
  - logic/hostCmdDecoder.sv
  - logic/serialMaster.sv
  - logic/serialSlave.sv
  - logic/resultCollector.sv
  - logic/busTop.sv
  - target: test
    files:
      - test/busTop_sva.sv
      - test/busChecker.sv
      - test/busTb.sv
